// ==== source/mb_regs_pkg.sv ====
////////////////////////////////////////
// motherboard register definitions
// widths, register map, compat number
// and the register port structs
////////////////////////////////////////

package mb_regs_pkg;

  localparam int REG_AWIDTH = 14;  // register port address width
  localparam int REG_DWIDTH = 32;  // register port data width

  // compat word is {major, minor}
  localparam logic [15:0] COMPAT_MAJOR = 16'd1;
  localparam logic [15:0] COMPAT_MINOR = 16'd0;

  ////////////////////////////////////////
  // register map
  typedef enum logic [REG_AWIDTH-1:0] {
    REG_COMPAT_NUM    = 14'h00,
    REG_DATESTAMP     = 14'h04,
    REG_GIT_HASH      = 14'h08,
    REG_SCRATCH       = 14'h0C,
    REG_NUM_CE        = 14'h10,
    REG_NUM_IO_CE     = 14'h14,
    REG_CLOCK_CTRL    = 14'h18,
    REG_XADC_READBACK = 14'h1C,
    REG_BUS_CLK_RATE  = 14'h20,
    REG_BUS_CLK_COUNT = 14'h24
  } reg_addr_e;

  ////////////////////////////////////////
  // register port
  typedef struct packed {
    logic                  req;   // one-cycle write strobe
    logic [REG_AWIDTH-1:0] addr;
    logic [REG_DWIDTH-1:0] data;
  } reg_wr_t;

  typedef struct packed {
    logic                  req;   // one-cycle read strobe
    logic [REG_AWIDTH-1:0] addr;
  } reg_rd_req_t;

  typedef struct packed {
    logic                  resp;  // one-cycle answer strobe
    logic [REG_DWIDTH-1:0] data;
  } reg_rd_resp_t;

  // clocking and pps controls
  typedef struct packed {
    logic [3:0] pps_select;
    logic       pps_out_enb;
    logic       ref_clk_reset;
    logic       meas_clk_reset;
  } clock_ctrl_t;

  localparam clock_ctrl_t CLOCK_CTRL_RESET = '{
    pps_select:     4'd1,   // internal pps by default
    pps_out_enb:    1'b0,
    ref_clk_reset:  1'b0,
    meas_clk_reset: 1'b0
  };

endpackage

// ==== source/mb_ctrl_regs.sv ====
////////////////////////////////////////
// motherboard writable registers
// scratch and clock control, updated
// on register port write strobes
////////////////////////////////////////

`timescale 1ns/1ps

module mb_ctrl_regs (
  input  logic                     bus_clk,
  input  logic                     bus_rst,
  input  mb_regs_pkg::reg_wr_t     i_reg_wr,
  output logic [31:0]              o_scratch,
  output mb_regs_pkg::clock_ctrl_t o_clock_ctrl
);

  logic [31:0]              scratch_q;
  mb_regs_pkg::clock_ctrl_t clock_ctrl_q;
  mb_regs_pkg::reg_addr_e   wr_addr;

  // map the raw address onto the register enum
  assign wr_addr = mb_regs_pkg::reg_addr_e'(i_reg_wr.addr);

  ////////////////////////////////////////
  // write decode
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      scratch_q    <= '0;
      clock_ctrl_q <= mb_regs_pkg::CLOCK_CTRL_RESET;
    end else if (i_reg_wr.req) begin
      case (wr_addr)
        mb_regs_pkg::REG_SCRATCH: begin
          scratch_q <= i_reg_wr.data;
        end
        mb_regs_pkg::REG_CLOCK_CTRL: begin
          clock_ctrl_q.pps_select     <= i_reg_wr.data[3:0];
          clock_ctrl_q.pps_out_enb    <= i_reg_wr.data[4];
          clock_ctrl_q.ref_clk_reset  <= i_reg_wr.data[8];   // bit 9 is ref lock, ro
          clock_ctrl_q.meas_clk_reset <= i_reg_wr.data[12];  // bit 13 is meas lock, ro
        end
        default: begin
          // read-only or npio address, nothing to store here
        end
      endcase
    end
  end

  assign o_scratch    = scratch_q;
  assign o_clock_ctrl = clock_ctrl_q;

endmodule

// ==== source/mb_readback.sv ====
////////////////////////////////////////
// motherboard read decode
// lock synchronizers, bus cycle counter
// and the registered read response for
// every address in the register map
////////////////////////////////////////

`timescale 1ns/1ps

module mb_readback #(
  parameter int unsigned BUS_CLK_RATE = 200000000,
  parameter logic [31:0] GIT_HASH     = 32'h0000_0000,
  parameter int unsigned NUM_CE       = 0,
  parameter int unsigned NUM_IO_CE    = 5
) (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  mb_regs_pkg::reg_rd_req_t  i_reg_rd,
  input  logic [31:0]               i_scratch,
  input  mb_regs_pkg::clock_ctrl_t  i_clock_ctrl,
  input  logic                      i_ref_clk_locked,   // async
  input  logic                      i_meas_clk_locked,  // async
  input  logic [31:0]               i_build_datestamp,
  input  logic [31:0]               i_xadc_readback,
  output mb_regs_pkg::reg_rd_resp_t o_rd
);

  logic [1:0]             lock_meta;   // {meas, ref}
  logic [1:0]             lock_sync;
  logic [31:0]            bus_counter;
  logic [31:0]            clock_ctrl_word;
  mb_regs_pkg::reg_addr_e rd_addr;
  logic                   rd_hit;
  logic [31:0]            rd_word;
  logic                   resp_q;
  logic [31:0]            data_q;

  ////////////////////////////////////////
  // lock synchronizers and bus counter
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta   <= '0;
      lock_sync   <= '0;
      bus_counter <= '0;
    end else begin
      lock_meta   <= {i_meas_clk_locked, i_ref_clk_locked};
      lock_sync   <= lock_meta;
      bus_counter <= bus_counter + 32'd1;  // free running, wraps
    end
  end

  // clock control readback layout, unused bits read 0
  always_comb begin
    clock_ctrl_word        = '0;
    clock_ctrl_word[3:0]   = i_clock_ctrl.pps_select;
    clock_ctrl_word[4]     = i_clock_ctrl.pps_out_enb;
    clock_ctrl_word[8]     = i_clock_ctrl.ref_clk_reset;
    clock_ctrl_word[9]     = lock_sync[0];
    clock_ctrl_word[12]    = i_clock_ctrl.meas_clk_reset;
    clock_ctrl_word[13]    = lock_sync[1];
  end

  ////////////////////////////////////////
  // read decode
  assign rd_addr = mb_regs_pkg::reg_addr_e'(i_reg_rd.addr);

  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (rd_addr)
      mb_regs_pkg::REG_COMPAT_NUM:
        rd_word = {mb_regs_pkg::COMPAT_MAJOR, mb_regs_pkg::COMPAT_MINOR};
      mb_regs_pkg::REG_DATESTAMP:     rd_word = i_build_datestamp;
      mb_regs_pkg::REG_GIT_HASH:      rd_word = GIT_HASH;
      mb_regs_pkg::REG_SCRATCH:       rd_word = i_scratch;
      mb_regs_pkg::REG_NUM_CE:        rd_word = 32'(NUM_CE);
      mb_regs_pkg::REG_NUM_IO_CE:     rd_word = 32'(NUM_IO_CE);
      mb_regs_pkg::REG_CLOCK_CTRL:    rd_word = clock_ctrl_word;
      mb_regs_pkg::REG_XADC_READBACK: rd_word = i_xadc_readback;
      mb_regs_pkg::REG_BUS_CLK_RATE:  rd_word = 32'(BUS_CLK_RATE);
      mb_regs_pkg::REG_BUS_CLK_COUNT: rd_word = bus_counter;  // count before this edge
      default:                        rd_hit  = 1'b0;         // left to npio
    endcase
  end

  // one-cycle resp pulse per hit
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= i_reg_rd.req & rd_hit;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (i_reg_rd.req && rd_hit) begin
      data_q <= rd_word;
    end
  end

  assign o_rd = '{resp: resp_q, data: data_q};

endmodule

// ==== source/regport_resp_mux.sv ====
////////////////////////////////////////
// register port response mux
// merges read answers of several
// slaves into one registered response
////////////////////////////////////////

`timescale 1ns/1ps

module regport_resp_mux #(
  parameter int NUM_SLAVES = 2
) (
  input  logic                      bus_clk,
  input  logic                      bus_rst,
  input  mb_regs_pkg::reg_rd_resp_t i_slv_rd [NUM_SLAVES],
  output mb_regs_pkg::reg_rd_resp_t o_rd
);

  logic        any_resp;
  logic [31:0] sel_data;
  logic        resp_q;
  logic [31:0] data_q;

  // walk down so the lowest answering slave wins
  always_comb begin
    any_resp = 1'b0;
    sel_data = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
      if (i_slv_rd[i].resp) begin
        any_resp = 1'b1;
        sel_data = i_slv_rd[i].data;
      end
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= any_resp;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (any_resp) begin
      data_q <= sel_data;  // held until the next answer
    end
  end

  assign o_rd = '{resp: resp_q, data: data_q};

endmodule

// ==== source/mb_core.sv ====
////////////////////////////////////////
// motherboard register block
// scratch, clock control and identity
// registers on the bus_clk register
// port, merged with the npio slave
////////////////////////////////////////

`timescale 1ns/1ps

module mb_core #(
  parameter int unsigned BUS_CLK_RATE = 200000000,  // bus_clk rate in Hz
  parameter logic [31:0] GIT_HASH     = 32'h0000_0000,
  parameter int unsigned NUM_CE       = 0,
  parameter int unsigned NUM_IO_CE    = 5
) (
  input  logic                       bus_clk,
  input  logic                       bus_rst,

  // register port from the master
  input  mb_regs_pkg::reg_wr_t       i_reg_wr,
  input  mb_regs_pkg::reg_rd_req_t   i_reg_rd,
  output mb_regs_pkg::reg_rd_resp_t  o_reg_rd,

  // register port to npio
  output mb_regs_pkg::reg_wr_t       o_npio_wr,
  output mb_regs_pkg::reg_rd_req_t   o_npio_rd,
  input  mb_regs_pkg::reg_rd_resp_t  i_npio_rd,

  // clocking
  input  logic                       i_ref_clk_locked,
  input  logic                       i_meas_clk_locked,
  output mb_regs_pkg::clock_ctrl_t   o_clock_ctrl,

  // misc readback
  input  logic [31:0]                i_build_datestamp,
  input  logic [31:0]                i_xadc_readback
);

  localparam int NUM_RD_SLAVES = 2;  // 0 = local regs, 1 = npio

  logic [31:0]               scratch;
  mb_regs_pkg::clock_ctrl_t  clock_ctrl;
  mb_regs_pkg::reg_rd_resp_t slv_rd [NUM_RD_SLAVES];

  // npio sees every request, it only answers its own addresses
  assign o_npio_wr    = i_reg_wr;
  assign o_npio_rd    = i_reg_rd;
  assign slv_rd[1]    = i_npio_rd;
  assign o_clock_ctrl = clock_ctrl;

  mb_ctrl_regs ctrl_regs_i (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_reg_wr     (i_reg_wr),
    .o_scratch    (scratch),
    .o_clock_ctrl (clock_ctrl)
  );

  mb_readback #(
    .BUS_CLK_RATE (BUS_CLK_RATE),
    .GIT_HASH     (GIT_HASH),
    .NUM_CE       (NUM_CE),
    .NUM_IO_CE    (NUM_IO_CE)
  ) readback_i (
    .bus_clk           (bus_clk),
    .bus_rst           (bus_rst),
    .i_reg_rd          (i_reg_rd),
    .i_scratch         (scratch),
    .i_clock_ctrl      (clock_ctrl),
    .i_ref_clk_locked  (i_ref_clk_locked),
    .i_meas_clk_locked (i_meas_clk_locked),
    .i_build_datestamp (i_build_datestamp),
    .i_xadc_readback   (i_xadc_readback),
    .o_rd              (slv_rd[0])
  );

  regport_resp_mux #(
    .NUM_SLAVES (NUM_RD_SLAVES)
  ) resp_mux_i (
    .bus_clk  (bus_clk),
    .bus_rst  (bus_rst),
    .i_slv_rd (slv_rd),
    .o_rd     (o_reg_rd)
  );

endmodule

// ==== sim/mb_core_properties.sv ====
////////////////////////////////////////
// mb_core port properties
// reset value of clock control, single
// cycle responses, local read latency
////////////////////////////////////////

`timescale 1ns/1ps

module mb_core_properties (
  input logic                      bus_clk,
  input logic                      bus_rst,
  input mb_regs_pkg::reg_wr_t      i_reg_wr,
  input mb_regs_pkg::reg_rd_req_t  i_reg_rd,
  input mb_regs_pkg::reg_rd_resp_t o_reg_rd,
  input mb_regs_pkg::clock_ctrl_t  o_clock_ctrl
);

  logic cc_written;  // a clock control write has been seen
  logic map_rd;      // read request to a local register

  assign map_rd = i_reg_rd.req && (i_reg_rd.addr inside {
    mb_regs_pkg::REG_COMPAT_NUM, mb_regs_pkg::REG_DATESTAMP,
    mb_regs_pkg::REG_GIT_HASH, mb_regs_pkg::REG_SCRATCH,
    mb_regs_pkg::REG_NUM_CE, mb_regs_pkg::REG_NUM_IO_CE,
    mb_regs_pkg::REG_CLOCK_CTRL, mb_regs_pkg::REG_XADC_READBACK,
    mb_regs_pkg::REG_BUS_CLK_RATE, mb_regs_pkg::REG_BUS_CLK_COUNT});

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      cc_written <= 1'b0;
    end else if (i_reg_wr.req && i_reg_wr.addr == mb_regs_pkg::REG_CLOCK_CTRL) begin
      cc_written <= 1'b1;
    end
  end

  ctrl_holds_reset: assert property (@(posedge bus_clk) disable iff (bus_rst)
    !cc_written |-> (o_clock_ctrl == mb_regs_pkg::CLOCK_CTRL_RESET))
    else $error("clock control left its reset value before a clock control write");

  resp_one_cycle: assert property (@(posedge bus_clk) disable iff (bus_rst)
    o_reg_rd.resp |=> !o_reg_rd.resp)
    else $error("read response held high for two cycles in a row");

  // request sampled two edges back shows up as resp now
  local_read_latency: assert property (@(posedge bus_clk) disable iff (bus_rst)
    $past(map_rd, 2) |-> o_reg_rd.resp)
    else $error("local register read did not answer two cycles after the request");

endmodule

bind mb_core mb_core_properties props_i (
  .bus_clk      (bus_clk),
  .bus_rst      (bus_rst),
  .i_reg_wr     (i_reg_wr),
  .i_reg_rd     (i_reg_rd),
  .o_reg_rd     (o_reg_rd),
  .o_clock_ctrl (o_clock_ctrl)
);

// ==== sim/mb_core_tb.sv ====
////////////////////////////////////////
// mb_core testbench
// drives the register port, acts as the
// npio slave and checks every read
// against a model of the register map
////////////////////////////////////////

`timescale 1ns/1ps

module mb_core_tb;

  localparam int unsigned BUS_RATE_HZ  = 125000000;  // 8 ns bus_clk
  localparam logic [31:0] GIT_HASH_VAL = 32'h3c5e_91a7;
  localparam int unsigned NUM_CE_VAL   = 2;
  localparam int unsigned NUM_IO_CE_VAL = 3;
  localparam logic [31:0] NPIO_PATTERN = 32'h5a3c_0000;

  logic                      bus_clk = 1'b0;
  logic                      bus_rst;
  mb_regs_pkg::reg_wr_t      reg_wr;
  mb_regs_pkg::reg_rd_req_t  reg_rd;
  mb_regs_pkg::reg_rd_resp_t reg_rd_resp;
  mb_regs_pkg::reg_wr_t      npio_wr;
  mb_regs_pkg::reg_rd_req_t  npio_rd;
  mb_regs_pkg::reg_rd_resp_t npio_rd_resp = '0;
  logic                      ref_locked;
  logic                      meas_locked;
  logic [31:0]               datestamp;
  logic [31:0]               xadc;
  mb_regs_pkg::clock_ctrl_t  clock_ctrl;

  integer                    seed;
  logic [31:0]               model_scratch;
  mb_regs_pkg::clock_ctrl_t  model_cc;
  logic [31:0]               model_count;   // bus cycles since reset
  logic [31:0]               exp_q [$];     // expected read data in request order
  logic [1:0]                npio_pend = '0;
  logic [13:0]               npio_addr [2] = '{default: '0};
  logic                      npio_hit;
  logic [13:0]               npio_req_addr;

  always #4 bus_clk = ~bus_clk;

  mb_core #(
    .BUS_CLK_RATE (BUS_RATE_HZ),
    .GIT_HASH     (GIT_HASH_VAL),
    .NUM_CE       (NUM_CE_VAL),
    .NUM_IO_CE    (NUM_IO_CE_VAL)
  ) UUT (
    .bus_clk           (bus_clk),
    .bus_rst           (bus_rst),
    .i_reg_wr          (reg_wr),
    .i_reg_rd          (reg_rd),
    .o_reg_rd          (reg_rd_resp),
    .o_npio_wr         (npio_wr),
    .o_npio_rd         (npio_rd),
    .i_npio_rd         (npio_rd_resp),
    .i_ref_clk_locked  (ref_locked),
    .i_meas_clk_locked (meas_locked),
    .o_clock_ctrl      (clock_ctrl),
    .i_build_datestamp (datestamp),
    .i_xadc_readback   (xadc)
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_clock_ctrl(input mb_regs_pkg::clock_ctrl_t got,
                                  input mb_regs_pkg::clock_ctrl_t exp, input string name);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_wr_req(input mb_regs_pkg::reg_wr_t got,
                              input mb_regs_pkg::reg_wr_t exp, input string name);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_rd_req(input mb_regs_pkg::reg_rd_req_t got,
                              input mb_regs_pkg::reg_rd_req_t exp, input string name);
    if (got !== exp) begin
      stop_with_error($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
  endtask

  task automatic check_latency(input int got, input int exp, input string name);
    if (got != exp) begin
      stop_with_error($sformatf("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp));
    end
  endtask

  function automatic bit is_reg_addr(input logic [13:0] addr);
    return addr inside {
      mb_regs_pkg::REG_COMPAT_NUM, mb_regs_pkg::REG_DATESTAMP,
      mb_regs_pkg::REG_GIT_HASH, mb_regs_pkg::REG_SCRATCH,
      mb_regs_pkg::REG_NUM_CE, mb_regs_pkg::REG_NUM_IO_CE,
      mb_regs_pkg::REG_CLOCK_CTRL, mb_regs_pkg::REG_XADC_READBACK,
      mb_regs_pkg::REG_BUS_CLK_RATE, mb_regs_pkg::REG_BUS_CLK_COUNT};
  endfunction

  ////////////////////////////////////////
  // reference model of the register map
  function automatic logic [31:0] expected_read(input logic [13:0] addr);
    logic [31:0] word;
    word = '0;
    case (addr)
      mb_regs_pkg::REG_COMPAT_NUM:
        word = {mb_regs_pkg::COMPAT_MAJOR, mb_regs_pkg::COMPAT_MINOR};
      mb_regs_pkg::REG_DATESTAMP:     word = datestamp;
      mb_regs_pkg::REG_GIT_HASH:      word = GIT_HASH_VAL;
      mb_regs_pkg::REG_SCRATCH:       word = model_scratch;
      mb_regs_pkg::REG_NUM_CE:        word = 32'(NUM_CE_VAL);
      mb_regs_pkg::REG_NUM_IO_CE:     word = 32'(NUM_IO_CE_VAL);
      mb_regs_pkg::REG_CLOCK_CTRL: begin
        word[3:0] = model_cc.pps_select;
        word[4]   = model_cc.pps_out_enb;
        word[8]   = model_cc.ref_clk_reset;
        word[9]   = ref_locked;    // held long enough to pass the synchronizer
        word[12]  = model_cc.meas_clk_reset;
        word[13]  = meas_locked;
      end
      mb_regs_pkg::REG_XADC_READBACK: word = xadc;
      mb_regs_pkg::REG_BUS_CLK_RATE:  word = 32'(BUS_RATE_HZ);
      mb_regs_pkg::REG_BUS_CLK_COUNT: word = model_count;
      default:                        word = {18'd0, addr} ^ NPIO_PATTERN;  // npio rule
    endcase
    return word;
  endfunction

  always @(posedge bus_clk) begin
    if (bus_rst) begin
      model_count <= '0;
    end else begin
      model_count <= model_count + 32'd1;
    end
  end

  // npio slave answers its own addresses two cycles after the request
  always begin
    @(posedge bus_clk);
    npio_hit      = !bus_rst && npio_rd.req && !is_reg_addr(npio_rd.addr);
    npio_req_addr = npio_rd.addr;
    #1;
    npio_rd_resp.resp = npio_pend[1];
    npio_rd_resp.data = {18'd0, npio_addr[1]} ^ NPIO_PATTERN;
    npio_pend         = {npio_pend[0], npio_hit};
    npio_addr[1]      = npio_addr[0];
    npio_addr[0]      = npio_req_addr;
  end

  // compare each response with the oldest expectation
  always @(posedge bus_clk) begin
    if (!bus_rst && reg_rd_resp.resp) begin
      if (exp_q.size() == 0) begin
        stop_with_error("a read response arrived with no read pending");
      end else begin
        check_word(reg_rd_resp.data, exp_q.pop_front(), "o_reg_rd.data");
      end
    end
  end

  ////////////////////////////////////////
  // bus tasks are entered 1 ns after an edge
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge bus_clk);
    #1;
  endtask

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    reg_wr = '{req: 1'b1, addr: addr, data: data};
    @(posedge bus_clk);
    check_wr_req(npio_wr, reg_wr, "o_npio_wr");
    #1;
    reg_wr.req = 1'b0;
    if (addr == mb_regs_pkg::REG_SCRATCH) begin
      model_scratch = data;
    end
    if (addr == mb_regs_pkg::REG_CLOCK_CTRL) begin
      model_cc.pps_select     = data[3:0];
      model_cc.pps_out_enb    = data[4];
      model_cc.ref_clk_reset  = data[8];
      model_cc.meas_clk_reset = data[12];
    end
    check_clock_ctrl(clock_ctrl, model_cc, "o_clock_ctrl");
  endtask

  task automatic read_reg(input logic [13:0] addr, output logic [31:0] data, output int lat);
    exp_q.push_back(expected_read(addr));
    reg_rd = '{req: 1'b1, addr: addr};
    @(posedge bus_clk);
    check_rd_req(npio_rd, reg_rd, "o_npio_rd");
    #1;
    reg_rd.req = 1'b0;
    lat = 1;  // edges since the request was driven
    while (reg_rd_resp.resp !== 1'b1) begin
      if (lat >= 20) begin
        stop_with_error($sformatf("no read response within 20 cycles for address %h", addr));
      end
      @(posedge bus_clk);
      #1;
      lat++;
    end
    data = reg_rd_resp.data;
  endtask

  task automatic read_and_check(input logic [13:0] addr);
    logic [31:0] data;
    int          lat;
    read_reg(addr, data, lat);
    if (is_reg_addr(addr)) begin
      check_latency(lat, 2, "read latency");
    end
  endtask

  ////////////////////////////////////////
  // test sequence
  initial begin
    logic [31:0] rnd;
    logic [31:0] count_a;
    logic [31:0] count_b;
    int          lat_a;
    int          lat_b;
    int          gap;
    logic [13:0] far_addr;

    seed          = 32'hfd236afe;
    bus_rst       = 1'b1;
    reg_wr        = '0;
    reg_rd        = '0;
    ref_locked    = 1'b0;
    meas_locked   = 1'b0;
    model_scratch = '0;
    model_cc      = mb_regs_pkg::CLOCK_CTRL_RESET;
    datestamp     = $random(seed);
    xadc          = $random(seed);
    repeat (2) @(posedge bus_clk);
    #1;
    bus_rst = 1'b0;

    // reset values
    check_clock_ctrl(clock_ctrl, mb_regs_pkg::CLOCK_CTRL_RESET, "o_clock_ctrl");
    read_and_check(mb_regs_pkg::REG_SCRATCH);
    read_and_check(mb_regs_pkg::REG_CLOCK_CTRL);

    // scratch and identity words
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      write_reg(mb_regs_pkg::REG_SCRATCH, rnd);
      read_and_check(mb_regs_pkg::REG_SCRATCH);
    end
    read_and_check(mb_regs_pkg::REG_COMPAT_NUM);
    read_and_check(mb_regs_pkg::REG_DATESTAMP);
    read_and_check(mb_regs_pkg::REG_GIT_HASH);
    read_and_check(mb_regs_pkg::REG_NUM_CE);
    read_and_check(mb_regs_pkg::REG_NUM_IO_CE);
    read_and_check(mb_regs_pkg::REG_XADC_READBACK);
    read_and_check(mb_regs_pkg::REG_BUS_CLK_RATE);

    // clock control with changing lock inputs
    for (int i = 0; i < 8; i++) begin
      rnd = $random(seed);
      write_reg(mb_regs_pkg::REG_CLOCK_CTRL, rnd);
      ref_locked  = rnd[20];
      meas_locked = rnd[21];
      idle_cycles(3);
      read_and_check(mb_regs_pkg::REG_CLOCK_CTRL);
    end

    // bus counter deltas
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      gap = 1 + int'(rnd[2:0]);
      read_reg(mb_regs_pkg::REG_BUS_CLK_COUNT, count_a, lat_a);
      idle_cycles(gap);
      read_reg(mb_regs_pkg::REG_BUS_CLK_COUNT, count_b, lat_b);
      check_latency(lat_a, 2, "read latency");
      check_latency(lat_b, 2, "read latency");
      check_word(count_b - count_a, 32'(lat_a + gap), "bus counter delta");
    end

    // bit 8 keeps the npio addresses out of the local map
    for (int i = 0; i < 6; i++) begin
      rnd      = $random(seed);
      far_addr = rnd[13:0] | 14'h0100;
      write_reg(far_addr, rnd);
      read_and_check(far_addr);
    end
    read_and_check(mb_regs_pkg::REG_SCRATCH);
    read_and_check(mb_regs_pkg::REG_CLOCK_CTRL);

    idle_cycles(4);
    if (exp_q.size() != 0) begin
      stop_with_error("a pending read never reached the compare process");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== project.f ====
source/mb_regs_pkg.sv
source/mb_ctrl_regs.sv
source/mb_readback.sv
source/regport_resp_mux.sv
source/mb_core.sv
sim/mb_core_properties.sv
sim/mb_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mb_core testbench with Verilator.
# Exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module mb_core_tb \
  --Mdir obj_dir \
  -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vmb_core_tb)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"; then
  exit 0
else
  echo "pass message not found in simulation output"
  exit 1
fi
